/* project.f */
verilog/hwloop_pkg.sv
verilog/hwloop_axil_cfg.sv
verilog/hwloop_regs.sv
verilog/hwloop_controller.sv
verilog/pc_sequencer.sv
verilog/hwloop_top.sv
tests/hwloop_checker.sv
tests/hwloop_tb.sv

/* tests/hwloop_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Hardware loop unit testbench
// Programs loops over AXI4-Lite, runs the fetch PC and compares every
// fetch address against a reference PC trace model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hwloop_tb;

  import hwloop_pkg::*;

  localparam int unsigned NUM_LOOPS = 2;
  localparam logic [31:0] BOOT_ADDR = 32'h0000_1000;
  localparam int unsigned CLK_NS    = 8;
  localparam int unsigned RESET_CYC = 16;

  // Watchdog budget from bus transfers and loop run phases
  localparam int unsigned XFER_MAX   = 120;
  localparam int unsigned XFER_CYC   = 16;
  localparam int unsigned RUN_PHASES = 4;
  localparam int unsigned RUN_MAX    = 64;
  localparam int unsigned MARGIN_CYC = 200;
  localparam int unsigned LIMIT_CYC  = RESET_CYC + XFER_MAX * XFER_CYC +
                                       RUN_PHASES * RUN_MAX + MARGIN_CYC;

  logic        clk_i;
  logic        arst_n_i;
  logic        run_i;
  axil_req_t   req;
  axil_rsp_t   rsp;
  logic [31:0] pc_o;
  logic        pc_valid_o;

  // Register model indexed by loop and field (start, end, count)
  logic [31:0] m_reg [NUM_LOOPS][3];
  logic [31:0] exp_pc;
  logic [31:0] lfsr_q = 32'h08b4_294e;
  int unsigned err_count = 0;

  hwloop_top #(
    .NUM_LOOPS (NUM_LOOPS),
    .BOOT_ADDR (BOOT_ADDR)
  ) i_dut (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .run_i      (run_i),
    .axil_req_i (req),
    .axil_rsp_o (rsp),
    .pc_o       (pc_o),
    .pc_valid_o (pc_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Offsets 0x0, 0x4, 0x8 inside an existing loop window
  function automatic logic addr_in_map(input logic [ADDR_W-1:0] a);
    return ((a[3:0] == 4'h0) || (a[3:0] == 4'h4) || (a[3:0] == 4'h8)) &&
           (a[ADDR_W-1:4] < NUM_LOOPS);
  endfunction

  // Next fetch address by the loop rule with the lowest index first
  function automatic logic [31:0] ref_next_pc(input logic [31:0] pc, output int taken);
    taken = -1;
    for (int i = 0; i < NUM_LOOPS; i++) begin
      if (taken < 0 && pc == m_reg[i][1] && m_reg[i][2] > 32'd1) begin
        taken = i;
      end
    end
    if (taken >= 0) begin
      return m_reg[taken][0];
    end
    return pc + 32'd4;
  endfunction

  task automatic fail_stop();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  // Write with a random number of cycles of bready held low
  task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                           output axil_resp_e resp);
    int unsigned hold;
    @(negedge clk_i);
    req.awaddr  = addr;
    req.awvalid = 1'b1;
    req.wdata   = data;
    req.wstrb   = 4'hf;
    req.wvalid  = 1'b1;
    req.bready  = 1'b0;
    do begin
      @(posedge clk_i);
    end while (!(rsp.awready && rsp.wready));
    @(negedge clk_i);
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    hold = rand_bits(3);
    repeat (hold) begin
      @(posedge clk_i);
      check("bvalid", rsp.bvalid, 1'b1);
    end
    @(negedge clk_i);
    req.bready = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!rsp.bvalid);
    resp = rsp.bresp;
    @(negedge clk_i);
    req.bready = 1'b0;
  endtask

  // Read with a random number of cycles of rready held low
  task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                          output axil_resp_e resp);
    int unsigned hold;
    @(negedge clk_i);
    req.araddr  = addr;
    req.arvalid = 1'b1;
    req.rready  = 1'b0;
    do begin
      @(posedge clk_i);
    end while (!rsp.arready);
    @(negedge clk_i);
    req.arvalid = 1'b0;
    hold = rand_bits(3);
    repeat (hold) begin
      @(posedge clk_i);
      check("rvalid", rsp.rvalid, 1'b1);
    end
    @(negedge clk_i);
    req.rready = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!rsp.rvalid);
    data = rsp.rdata;
    resp = rsp.rresp;
    @(negedge clk_i);
    req.rready = 1'b0;
  endtask

  // Register write, model update and response check
  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
    axil_resp_e resp;
    axi_write(addr, data, resp);
    if (addr_in_map(addr)) begin
      m_reg[addr[ADDR_W-1:4]][addr[3:2]] = data;
      check("bresp", resp, RESP_OKAY);
    end else begin
      check("bresp", resp, RESP_SLVERR);
    end
  endtask

  // Register read against the model with zero data expected outside the map
  task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
    axil_resp_e resp;
    axi_read(addr, data, resp);
    if (addr_in_map(addr)) begin
      check("rdata", data, m_reg[addr[ADDR_W-1:4]][addr[3:2]]);
      check("rresp", resp, RESP_OKAY);
    end else begin
      check("rdata", data, 32'd0);
      check("rresp", resp, RESP_SLVERR);
    end
  endtask

  // Run until the model reaches stop_pc, which is then not fetched
  task automatic run_until(input logic [31:0] stop_pc, output int unsigned fetched);
    fetched = 0;
    @(negedge clk_i);
    run_i = 1'b1;
    while (run_i) begin
      @(negedge clk_i);
      fetched++;
      if (exp_pc == stop_pc) begin
        run_i = 1'b0;
      end else if (fetched >= RUN_MAX) begin
        $display("Loop run did not reach 0x%08h within %0d cycles", stop_pc, RUN_MAX);
        fail_stop();
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // PC trace compare
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : compare_pc
    logic [31:0] nxt;
    int          taken;
    if (arst_n_i && pc_valid_o) begin
      check("pc_o", pc_o, exp_pc);
      nxt = ref_next_pc(exp_pc, taken);
      // Counter steps down on the same edge as the jump
      if (taken >= 0) begin
        m_reg[taken][2] = m_reg[taken][2] - 32'd1;
      end
      exp_pc = nxt;
    end
  end

  initial begin : watchdog
    #(LIMIT_CYC * CLK_NS);
    $display("Run timed out after %0d cycles", LIMIT_CYC);
    fail_stop();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0]       data;
    logic [31:0]       base;
    logic [ADDR_W-1:0] bad_addr [4];
    int unsigned       len;
    int unsigned       cnt;
    int unsigned       fetched;
    int unsigned       pre;
    int unsigned       body;
    int unsigned       post;
    int unsigned       cnt0;
    int unsigned       cnt1;
    run_i    = 1'b0;
    req      = '0;
    arst_n_i = 1'b0;
    exp_pc   = BOOT_ADDR;
    for (int i = 0; i < NUM_LOOPS; i++) begin
      for (int f = 0; f < 3; f++) begin
        m_reg[i][f] = '0;
      end
    end
    repeat (RESET_CYC) @(negedge clk_i);
    arst_n_i = 1'b1;
    check("pc_o", pc_o, BOOT_ADDR);
    check("pc_valid_o", pc_valid_o, 1'b0);

    // Every field of every loop read back twice with idle cycles between
    for (int i = 0; i < NUM_LOOPS; i++) begin
      for (int f = 0; f < 3; f++) begin
        if (f == 1) begin
          // End address on the held PC so a stopped core would show any stray decrement
          write_reg(ADDR_W'(i * 16 + f * 4), exp_pc);
        end else begin
          write_reg(ADDR_W'(i * 16 + f * 4), rand_bits(32) | 32'd2);
        end
      end
    end
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < NUM_LOOPS; i++) begin
        for (int f = 0; f < 3; f++) begin
          read_reg(ADDR_W'(i * 16 + f * 4), data);
        end
      end
      repeat (rand_bits(4)) @(negedge clk_i);
    end
    // Park both counters
    for (int i = 0; i < NUM_LOOPS; i++) begin
      write_reg(ADDR_W'(i * 16 + 8), 32'd0);
    end

    // Single loop starting at the current PC
    len  = 1 + rand_bits(3);
    cnt  = 2 + rand_bits(2);
    base = exp_pc;
    write_reg(12'h000, base);
    write_reg(12'h004, base + 4 * (len - 1));
    write_reg(12'h008, cnt);
    run_until(base + 4 * len, fetched);
    check("fetch count", fetched, len * cnt);
    read_reg(12'h008, data);
    check("loop0 count", data, 32'd1);

    // Loop 0 nested in loop 1 with a shared end address on the first pass
    for (int k = 0; k < 2; k++) begin
      pre  = rand_bits(2);
      body = 1 + rand_bits(2);
      post = (k == 0) ? 0 : 1 + rand_bits(1);
      cnt0 = 2 + rand_bits(1);
      cnt1 = 2 + rand_bits(1);
      base = exp_pc;
      write_reg(12'h000, base + 4 * pre);
      write_reg(12'h004, base + 4 * (pre + body - 1));
      write_reg(12'h008, cnt0);
      write_reg(12'h010, base);
      write_reg(12'h014, base + 4 * (pre + body - 1 + post));
      write_reg(12'h018, cnt1);
      run_until(base + 4 * (pre + body + post), fetched);
      read_reg(12'h008, data);
      read_reg(12'h018, data);
    end

    // Counters of 0 and 1 at the end address fall through
    cnt0 = rand_bits(1);
    cnt1 = 1 - cnt0;
    base = exp_pc;
    write_reg(12'h004, base + 8);
    write_reg(12'h008, cnt0);
    write_reg(12'h014, base + 8);
    write_reg(12'h018, cnt1);
    run_until(base + 16, fetched);
    check("fetch count", fetched, 32'd4);
    read_reg(12'h008, data);
    check("loop0 count", data, cnt0);
    read_reg(12'h018, data);
    check("loop1 count", data, cnt1);

    // Unused offset, missing loop, unaligned and far out of map
    bad_addr = '{12'h00C, 12'h020, 12'h006, 12'hFF0};
    for (int k = 0; k < 4; k++) begin
      write_reg(bad_addr[k], rand_bits(32));
      read_reg(bad_addr[k], data);
    end
    for (int i = 0; i < NUM_LOOPS; i++) begin
      for (int f = 0; f < 3; f++) begin
        read_reg(ADDR_W'(i * 16 + f * 4), data);
      end
    end

    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/hwloop_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Hardware loop unit protocol checker
// Concurrent assertions on the fetch PC, loop decrement and AXI4-Lite
// response hold, bound into the top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hwloop_checker #(
  parameter int unsigned NUM_LOOPS = 2
) (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input logic [31:0]           pc_i,
  input logic                  pc_valid_i,
  input logic [NUM_LOOPS-1:0]  dec_cnt_i,
  input logic                  jump_i,
  input logic [31:0]           jump_target_i,
  input hwloop_pkg::axil_req_t axil_req_i,
  input hwloop_pkg::axil_rsp_t axil_rsp_i
);

  // No fetch while the unit sits in reset
  a_valid_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !pc_valid_i)
    else $error("pc_valid_o high during reset");

  // At most one loop counts down per cycle
  a_dec_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(dec_cnt_i))
    else $error("dec_cnt has more than one bit set");

  // A taken jump lands on the target of the previous cycle
  a_jump_lands: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    jump_i |=> (pc_i == $past(jump_target_i)))
    else $error("pc_o did not follow the jump target");

  // Responses stay up until the master takes them
  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    axil_rsp_i.rvalid && !axil_req_i.rready |=> axil_rsp_i.rvalid)
    else $error("rvalid dropped before rready");

endmodule

bind hwloop_top hwloop_checker #(
  .NUM_LOOPS (NUM_LOOPS)
) i_checker (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .pc_i          (pc_o),
  .pc_valid_i    (pc_valid_o),
  .dec_cnt_i     (dec_cnt),
  .jump_i        (jump),
  .jump_target_i (jump_target),
  .axil_req_i    (axil_req_i),
  .axil_rsp_i    (axil_rsp_o)
);

`default_nettype wire

/* verilog/hwloop_top.sv */
////////////////////////////////////////////////////////////////////////////
// Hardware loop unit top level
// AXI4-Lite configuration, loop register bank, loop controller and
// fetch PC sequencer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hwloop_top #(
  parameter int unsigned NUM_LOOPS = 2,
  parameter logic [31:0] BOOT_ADDR = 32'h0000_1000
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  run_i,
  input  hwloop_pkg::axil_req_t axil_req_i,
  output hwloop_pkg::axil_rsp_t axil_rsp_o,
  output logic [31:0]           pc_o,
  output logic                  pc_valid_o
);

  import hwloop_pkg::*;

  // Bus side of the register bank
  logic [NUM_LOOPS-1:0]        cfg_we;
  reg_sel_e                    cfg_sel;
  logic [31:0]                 cfg_wdata;
  hwloop_cfg_t [NUM_LOOPS-1:0] loop_cfg;

  // Loop decision
  logic [NUM_LOOPS-1:0]        dec_cnt;
  logic                        jump;
  logic [31:0]                 jump_target;

  hwloop_axil_cfg #(
    .NUM_LOOPS (NUM_LOOPS)
  ) i_axil_cfg (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .axil_req_i  (axil_req_i),
    .axil_rsp_o  (axil_rsp_o),
    .loop_cfg_i  (loop_cfg),
    .cfg_we_o    (cfg_we),
    .cfg_sel_o   (cfg_sel),
    .cfg_wdata_o (cfg_wdata)
  );

  hwloop_regs #(
    .NUM_LOOPS (NUM_LOOPS)
  ) i_regs (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_we_i    (cfg_we),
    .cfg_sel_i   (cfg_sel),
    .cfg_wdata_i (cfg_wdata),
    .dec_cnt_i   (dec_cnt),
    .loop_cfg_o  (loop_cfg)
  );

  // Only a running core counts loops down
  hwloop_controller #(
    .NUM_LOOPS (NUM_LOOPS)
  ) i_controller (
    .enable_i      (run_i),
    .current_pc_i  (pc_o),
    .loop_cfg_i    (loop_cfg),
    .dec_cnt_o     (dec_cnt),
    .jump_o        (jump),
    .jump_target_o (jump_target)
  );

  pc_sequencer #(
    .BOOT_ADDR (BOOT_ADDR)
  ) i_pc_sequencer (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .run_i         (run_i),
    .jump_i        (jump),
    .jump_target_i (jump_target),
    .pc_o          (pc_o),
    .pc_valid_o    (pc_valid_o)
  );

endmodule

`default_nettype wire

/* verilog/pc_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// Fetch program counter
// Steps by one word per running cycle or takes the loop jump target
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pc_sequencer #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_1000
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        run_i,
  input  logic        jump_i,
  input  logic [31:0] jump_target_i,
  output logic [31:0] pc_o,
  output logic        pc_valid_o
);

  logic [31:0] pc_q;
  logic [31:0] pc_d;

  // Next fetch address
  always_comb begin
    pc_d = pc_q;
    if (run_i) begin
      if (jump_i) begin
        pc_d = jump_target_i;
      end else begin
        // Sequential fetch, 32 bit instructions
        pc_d = pc_q + 32'd4;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= BOOT_ADDR;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

  // Every running cycle presents one fetch address
  assign pc_valid_o = run_i;

endmodule

`default_nettype wire

/* verilog/hwloop_controller.sv */
////////////////////////////////////////////////////////////////////////////
// Hardware loop controller
// Compares the fetch PC with each loop end address and picks the jump
// target, lowest loop index first
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hwloop_controller #(
  parameter int unsigned NUM_LOOPS = 2
) (
  input  logic                                    enable_i,
  input  logic [31:0]                             current_pc_i,
  input  hwloop_pkg::hwloop_cfg_t [NUM_LOOPS-1:0] loop_cfg_i,
  output logic [NUM_LOOPS-1:0]                    dec_cnt_o,
  output logic                                    jump_o,
  output logic [31:0]                             jump_target_o
);

  // Loops that would take the branch back this cycle
  logic [NUM_LOOPS-1:0] loop_hit;

  ////////////////////////////////////////////////////////////////////////////
  // Comparators
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_LOOPS; i++) begin : g_cmp
    // End reached and at least one more pass left
    assign loop_hit[i] = enable_i &&
                         (current_pc_i == loop_cfg_i[i].end_addr) &&
                         (loop_cfg_i[i].count > 32'd1);
  end

  assign jump_o = |loop_hit;

  ////////////////////////////////////////////////////////////////////////////
  // Priority select
  ////////////////////////////////////////////////////////////////////////////

  // Lowest index wins, so an inner loop sits below its outer loop
  always_comb begin : p_select
    logic found;
    found         = 1'b0;
    dec_cnt_o     = '0;
    jump_target_o = '0;
    for (int i = 0; i < NUM_LOOPS; i++) begin
      if (loop_hit[i] && !found) begin
        found         = 1'b1;
        dec_cnt_o[i]  = 1'b1;
        jump_target_o = loop_cfg_i[i].start_addr;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/hwloop_regs.sv */
////////////////////////////////////////////////////////////////////////////
// Hardware loop register bank
// Start, end and iteration counter per loop, written from the bus and
// counted down by the loop controller
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hwloop_regs #(
  parameter int unsigned NUM_LOOPS = 2
) (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  logic [NUM_LOOPS-1:0]                    cfg_we_i,
  input  hwloop_pkg::reg_sel_e                    cfg_sel_i,
  input  logic [31:0]                             cfg_wdata_i,
  input  logic [NUM_LOOPS-1:0]                    dec_cnt_i,
  output hwloop_pkg::hwloop_cfg_t [NUM_LOOPS-1:0] loop_cfg_o
);

  import hwloop_pkg::*;

  hwloop_cfg_t [NUM_LOOPS-1:0] cfg_q;

  ////////////////////////////////////////////////////////////////////////////
  // One register set per loop
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_LOOPS; i++) begin : g_loop
    logic wr_start;
    logic wr_end;
    logic wr_count;

    // Field strobes for this loop
    assign wr_start = cfg_we_i[i] && (cfg_sel_i == SEL_START);
    assign wr_end   = cfg_we_i[i] && (cfg_sel_i == SEL_END);
    assign wr_count = cfg_we_i[i] && (cfg_sel_i == SEL_COUNT);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        cfg_q[i] <= '0;
      end else begin
        if (wr_start) begin
          cfg_q[i].start_addr <= cfg_wdata_i;
        end
        if (wr_end) begin
          cfg_q[i].end_addr <= cfg_wdata_i;
        end
        // Bus write beats a decrement landing on the same edge
        if (wr_count) begin
          cfg_q[i].count <= cfg_wdata_i;
        end else if (dec_cnt_i[i]) begin
          cfg_q[i].count <= cfg_q[i].count - 32'd1;
        end
      end
    end
  end

  // Bank contents go to both the bus slave and the controller
  assign loop_cfg_o = cfg_q;

endmodule

`default_nettype wire

/* verilog/hwloop_axil_cfg.sv */
////////////////////////////////////////////////////////////////////////////
// Hardware loop configuration slave
// AXI4-Lite port onto the loop register bank, one 16 byte window per loop
// Writes take priority over reads, bad addresses answer SLVERR
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hwloop_axil_cfg #(
  parameter int unsigned NUM_LOOPS = 2
) (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  hwloop_pkg::axil_req_t                   axil_req_i,
  output hwloop_pkg::axil_rsp_t                   axil_rsp_o,
  input  hwloop_pkg::hwloop_cfg_t [NUM_LOOPS-1:0] loop_cfg_i,
  output logic [NUM_LOOPS-1:0]                    cfg_we_o,
  output hwloop_pkg::reg_sel_e                    cfg_sel_o,
  output logic [31:0]                             cfg_wdata_o
);

  import hwloop_pkg::*;

  // Loop index field above the 16 byte window
  localparam int unsigned IDX_W = ADDR_W - 4;

  // Word aligned, known field and loop index inside the bank
  function automatic logic addr_valid(input logic [ADDR_W-1:0] addr);
    logic [IDX_W-1:0] idx;
    idx = addr[ADDR_W-1:4];
    return (addr[1:0] == 2'b00) && (addr[3:2] != 2'b11) && (idx < NUM_LOOPS);
  endfunction

  axil_state_e      state_q;
  axil_state_e      state_d;
  logic             wr_go;
  logic             rd_go;
  logic             wr_ok;
  logic             rd_ok;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  reg_sel_e         rd_sel;
  logic [31:0]      rd_field;
  axil_resp_e       bresp_q;
  axil_resp_e       rresp_q;
  logic [31:0]      rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Acceptance and address decode
  ////////////////////////////////////////////////////////////////////////////

  // Write needs address and data together, read only when no write waits
  assign wr_go = (state_q == ST_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
  assign rd_go = (state_q == ST_IDLE) && axil_req_i.arvalid &&
                 !(axil_req_i.awvalid && axil_req_i.wvalid);

  assign wr_ok  = addr_valid(axil_req_i.awaddr);
  assign rd_ok  = addr_valid(axil_req_i.araddr);
  assign wr_idx = axil_req_i.awaddr[ADDR_W-1:4];
  assign rd_idx = axil_req_i.araddr[ADDR_W-1:4];
  assign rd_sel = reg_sel_e'(axil_req_i.araddr[3:2]);

  // One-hot write enable, nothing for a rejected address
  always_comb begin
    cfg_we_o = '0;
    for (int i = 0; i < NUM_LOOPS; i++) begin
      cfg_we_o[i] = wr_go && wr_ok && (wr_idx == i);
    end
  end

  assign cfg_sel_o   = reg_sel_e'(axil_req_i.awaddr[3:2]);
  // Whole word writes, strobes not looked at
  assign cfg_wdata_o = axil_req_i.wdata;

  // Field picked by the read address
  always_comb begin
    rd_field = '0;
    for (int i = 0; i < NUM_LOOPS; i++) begin
      if (rd_idx == i) begin
        case (rd_sel)
          SEL_START: rd_field = loop_cfg_i[i].start_addr;
          SEL_END:   rd_field = loop_cfg_i[i].end_addr;
          SEL_COUNT: rd_field = loop_cfg_i[i].count;
          default:   rd_field = '0;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (wr_go) begin
          state_d = ST_WRESP;
        end else if (rd_go) begin
          state_d = ST_RRESP;
        end
      end
      // Hold the response until the master takes it
      ST_WRESP: if (axil_req_i.bready) state_d = ST_IDLE;
      ST_RRESP: if (axil_req_i.rready) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Response payload captured at acceptance
  always_ff @(posedge clk_i) begin
    if (wr_go) begin
      bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_go) begin
      rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      rdata_q <= rd_ok ? rd_field : '0;
    end
  end

  always_comb begin
    axil_rsp_o.awready = wr_go;
    axil_rsp_o.wready  = wr_go;
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.bvalid  = (state_q == ST_WRESP);
    axil_rsp_o.arready = rd_go;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
    axil_rsp_o.rvalid  = (state_q == ST_RRESP);
  end

endmodule

`default_nettype wire

/* verilog/hwloop_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Hardware loop unit shared types
// AXI4-Lite request and response bundles, response and state encodings,
// per-loop register layout and register field select
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package hwloop_pkg;

  // Configuration bus address width in bits
  parameter int unsigned ADDR_W = 12;

  // AXI4-Lite response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // States of the configuration slave
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_WRESP = 2'd1,
    ST_RRESP = 2'd2
  } axil_state_e;

  // Field inside one loop's 16 byte window, taken from address bits [3:2]
  typedef enum logic [1:0] {
    SEL_START = 2'd0,
    SEL_END   = 2'd1,
    SEL_COUNT = 2'd2
  } reg_sel_e;

  // Master to slave
  typedef struct packed {
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic [31:0]       wdata;
    logic [3:0]        wstrb;
    logic              wvalid;
    logic              bready;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              rready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic              awready;
    logic              wready;
    axil_resp_e        bresp;
    logic              bvalid;
    logic              arready;
    logic [31:0]       rdata;
    axil_resp_e        rresp;
    logic              rvalid;
  } axil_rsp_t;

  // Registers of one hardware loop
  typedef struct packed {
    logic [31:0] start_addr;
    logic [31:0] end_addr;
    logic [31:0] count;
  } hwloop_cfg_t;

endpackage

`default_nettype wire
